// File: Bender.yml
package:
  name: lite_pipe

sources:
  - source/lite_pkg.sv
  - source/ex_bus_if.sv
  - source/alu.sv
  - source/id_stage.sv
  - source/ex_stage.sv
  - source/mem_stage.sv
  - source/lite_pipe_top.sv
  - target: test
    files:
      - verif/tb_clock.sv
      - verif/lite_pipe_checker.sv
      - verif/tb_lite_pipe.sv

// File: flist.f
source/lite_pkg.sv
source/ex_bus_if.sv
source/alu.sv
source/id_stage.sv
source/ex_stage.sv
source/mem_stage.sv
source/lite_pipe_top.sv
verif/tb_clock.sv
verif/lite_pipe_checker.sv
verif/tb_lite_pipe.sv

// File: source/alu.sv
`default_nettype none

module alu (
    input logic [11:0] alu_op,
    input logic [31:0] alu_src1,
    input logic [31:0] alu_src2,
    output logic [31:0] alu_result
);

    logic do_sub;
    logic [31:0] adder_b;
    logic [31:0] sum;
    logic carry;
    logic slt_bit;
    logic sltu_bit;
    logic [31:0] sll_result;
    logic [31:0] srl_result;
    logic [31:0] sra_result;

    // compares reuse the subtractor
    assign do_sub = alu_op[lite_pkg::op_sub] | alu_op[lite_pkg::op_slt]
                  | alu_op[lite_pkg::op_sltu];
    assign adder_b = do_sub ? ~alu_src2 : alu_src2;
    assign {carry, sum} = {1'b0, alu_src1} + {1'b0, adder_b} + {32'b0, do_sub};

    assign slt_bit = (alu_src1[31] & ~alu_src2[31])
                   | (~(alu_src1[31] ^ alu_src2[31]) & sum[31]);
    assign sltu_bit = ~carry; // borrow out

    assign sll_result = alu_src1 << alu_src2[4:0];
    assign srl_result = alu_src1 >> alu_src2[4:0];
    assign sra_result = $signed(alu_src1) >>> alu_src2[4:0];

    assign alu_result =
          ({32{alu_op[lite_pkg::op_add] | alu_op[lite_pkg::op_sub]}} & sum)
        | ({32{alu_op[lite_pkg::op_slt]}} & {31'b0, slt_bit})
        | ({32{alu_op[lite_pkg::op_sltu]}} & {31'b0, sltu_bit})
        | ({32{alu_op[lite_pkg::op_and]}} & (alu_src1 & alu_src2))
        | ({32{alu_op[lite_pkg::op_nor]}} & ~(alu_src1 | alu_src2))
        | ({32{alu_op[lite_pkg::op_or]}} & (alu_src1 | alu_src2))
        | ({32{alu_op[lite_pkg::op_xor]}} & (alu_src1 ^ alu_src2))
        | ({32{alu_op[lite_pkg::op_sll]}} & sll_result)
        | ({32{alu_op[lite_pkg::op_srl]}} & srl_result)
        | ({32{alu_op[lite_pkg::op_sra]}} & sra_result);

endmodule

`default_nettype wire

// File: source/ex_bus_if.sv
`default_nettype none

interface ex_bus_if;
    logic valid;
    logic ready;
    logic [lite_pkg::xlen-1:0] pc;
    logic [11:0] alu_op;
    logic [7:0] load_op;
    logic src2_is_imm;
    logic res_from_mem;
    logic gr_we;
    logic mem_we;
    logic [4:0] dest;
    logic [lite_pkg::xlen-1:0] imm;
    logic [lite_pkg::xlen-1:0] rj_value;
    logic [lite_pkg::xlen-1:0] rkd_value;

    modport producer (
        output valid, pc, alu_op, load_op, src2_is_imm, res_from_mem,
        output gr_we, mem_we, dest, imm, rj_value, rkd_value,
        input ready
    );

    modport consumer (
        input valid, pc, alu_op, load_op, src2_is_imm, res_from_mem,
        input gr_we, mem_we, dest, imm, rj_value, rkd_value,
        output ready
    );
endinterface

interface mem_bus_if;
    logic valid;
    logic ready;
    logic [lite_pkg::xlen-1:0] pc;
    logic [lite_pkg::xlen-1:0] alu_result;
    logic [7:0] load_op;
    logic res_from_mem;
    logic gr_we;
    logic mem_we;
    logic [4:0] dest;
    logic [lite_pkg::xlen-1:0] rkd_value;

    modport producer (
        output valid, pc, alu_result, load_op, res_from_mem, gr_we, mem_we,
        output dest, rkd_value,
        input ready
    );

    modport consumer (
        input valid, pc, alu_result, load_op, res_from_mem, gr_we, mem_we,
        input dest, rkd_value,
        output ready
    );
endinterface

`default_nettype wire

// File: source/ex_stage.sv
`default_nettype none

module ex_stage (
    input logic clk,
    input logic rst,
    ex_bus_if.consumer up,
    mem_bus_if.producer down
);

    logic [31:0] alu_src2;
    logic [31:0] alu_result;
    logic accept;

    assign up.ready = ~rst & (~down.valid | down.ready);
    assign accept = up.valid & up.ready;

    assign alu_src2 = up.src2_is_imm ? up.imm : up.rkd_value;

    alu i_alu (
        .alu_op(up.alu_op),
        .alu_src1(up.rj_value),
        .alu_src2(alu_src2),
        .alu_result(alu_result)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            down.valid <= 1'b0;
        end else if (up.ready) begin
            down.valid <= up.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            down.pc <= up.pc;
            down.alu_result <= alu_result;
            down.load_op <= up.load_op;
            down.res_from_mem <= up.res_from_mem;
            down.gr_we <= up.gr_we;
            down.mem_we <= up.mem_we;
            down.dest <= up.dest;
            down.rkd_value <= up.rkd_value; // store data
        end
    end

endmodule

`default_nettype wire

// File: source/id_stage.sv
`default_nettype none

module id_stage (
    input logic clk,
    input logic rst,
    input logic in_valid,
    output logic in_ready,
    input logic [31:0] inst,
    input logic [31:0] pc,
    input logic [31:0] rj_value,
    input logic [31:0] rkd_value,
    ex_bus_if.producer down
);

    lite_pkg::inst_word_u inst_q;
    logic [31:0] pc_q;
    logic [31:0] rj_q;
    logic [31:0] rkd_q;
    logic out_valid;
    logic accept;

    logic [11:0] r3_op;
    logic [11:0] ri_op;
    logic [7:0] ld_sel;
    logic is_load;
    logic is_store;
    logic imm_zext;

    assign in_ready = ~rst & (~out_valid | down.ready);
    assign accept = in_valid & in_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            inst_q <= inst;
            pc_q <= pc;
            rj_q <= rj_value;
            rkd_q <= rkd_value;
        end
    end

    always_comb begin
        r3_op = '0;
        ri_op = '0;
        ld_sel = '0;
        is_store = 1'b0;
        case (inst_q.r3.opcode)
            lite_pkg::opc_add_w: r3_op[lite_pkg::op_add] = 1'b1;
            lite_pkg::opc_sub_w: r3_op[lite_pkg::op_sub] = 1'b1;
            lite_pkg::opc_slt: r3_op[lite_pkg::op_slt] = 1'b1;
            lite_pkg::opc_sltu: r3_op[lite_pkg::op_sltu] = 1'b1;
            lite_pkg::opc_nor: r3_op[lite_pkg::op_nor] = 1'b1;
            lite_pkg::opc_and: r3_op[lite_pkg::op_and] = 1'b1;
            lite_pkg::opc_or: r3_op[lite_pkg::op_or] = 1'b1;
            lite_pkg::opc_xor: r3_op[lite_pkg::op_xor] = 1'b1;
            lite_pkg::opc_sll_w: r3_op[lite_pkg::op_sll] = 1'b1;
            lite_pkg::opc_srl_w: r3_op[lite_pkg::op_srl] = 1'b1;
            lite_pkg::opc_sra_w: r3_op[lite_pkg::op_sra] = 1'b1;
            default: r3_op = '0;
        endcase
        case (inst_q.ri12.opcode)
            lite_pkg::opc_addi_w: ri_op[lite_pkg::op_add] = 1'b1;
            lite_pkg::opc_slti: ri_op[lite_pkg::op_slt] = 1'b1;
            lite_pkg::opc_sltui: ri_op[lite_pkg::op_sltu] = 1'b1;
            lite_pkg::opc_andi: ri_op[lite_pkg::op_and] = 1'b1;
            lite_pkg::opc_ori: ri_op[lite_pkg::op_or] = 1'b1;
            lite_pkg::opc_xori: ri_op[lite_pkg::op_xor] = 1'b1;
            lite_pkg::opc_ld_b: ld_sel[lite_pkg::ld_b] = 1'b1;
            lite_pkg::opc_ld_h: ld_sel[lite_pkg::ld_h] = 1'b1;
            lite_pkg::opc_ld_w: ld_sel[lite_pkg::ld_w] = 1'b1;
            lite_pkg::opc_ld_bu: ld_sel[lite_pkg::ld_bu] = 1'b1;
            lite_pkg::opc_ld_hu: ld_sel[lite_pkg::ld_hu] = 1'b1;
            lite_pkg::opc_st_w: is_store = 1'b1;
            default: ri_op = '0;
        endcase
    end

    assign is_load = |ld_sel;
    // logic immediates are zero-extended, arithmetic ones sign-extended
    assign imm_zext = ri_op[lite_pkg::op_and] | ri_op[lite_pkg::op_or] | ri_op[lite_pkg::op_xor];

    assign down.valid = out_valid;
    assign down.pc = pc_q;
    assign down.alu_op = r3_op | ri_op | {11'b0, is_load | is_store}; // address via add
    assign down.load_op = ld_sel;
    assign down.src2_is_imm = (|ri_op) | is_load | is_store;
    assign down.res_from_mem = is_load;
    assign down.gr_we = (|r3_op) | (|ri_op) | is_load; // unknown opcode writes nothing
    assign down.mem_we = is_store;
    assign down.dest = inst_q.r3.rd;
    assign down.imm = imm_zext ? {20'b0, inst_q.ri12.imm12}
                               : {{20{inst_q.ri12.imm12[11]}}, inst_q.ri12.imm12};
    assign down.rj_value = rj_q;
    assign down.rkd_value = rkd_q;

endmodule

`default_nettype wire

// File: source/lite_pipe_top.sv
`default_nettype none

module lite_pipe_top (
    input logic clk,
    input logic rst,
    input logic inst_valid,
    output logic inst_ready,
    input logic [31:0] inst,
    input logic [31:0] pc,
    input logic [31:0] rj_value,
    input logic [31:0] rkd_value,
    input logic wb_ready,
    output logic wb_valid,
    output logic [31:0] wb_pc,
    output logic [4:0] wb_dest,
    output logic wb_we,
    output logic [31:0] wb_data
);

    ex_bus_if ex_bus ();
    mem_bus_if mem_bus ();

    id_stage i_id_stage (
        .clk(clk),
        .rst(rst),
        .in_valid(inst_valid),
        .in_ready(inst_ready),
        .inst(inst),
        .pc(pc),
        .rj_value(rj_value),
        .rkd_value(rkd_value),
        .down(ex_bus.producer)
    );

    ex_stage i_ex_stage (
        .clk(clk),
        .rst(rst),
        .up(ex_bus.consumer),
        .down(mem_bus.producer)
    );

    mem_stage i_mem_stage (
        .clk(clk),
        .rst(rst),
        .up(mem_bus.consumer),
        .wb_ready(wb_ready),
        .wb_valid(wb_valid),
        .wb_we(wb_we),
        .wb_pc(wb_pc),
        .wb_data(wb_data),
        .wb_dest(wb_dest)
    );

endmodule

`default_nettype wire

// File: source/lite_pkg.sv
`default_nettype none

package lite_pkg;

    localparam int xlen = 32;
    localparam logic [31:0] reset_pc = 32'h1c000000;
    localparam int dmem_words = 64;

    // one-hot bit positions of alu_op
    localparam int op_add = 0;
    localparam int op_sub = 1;
    localparam int op_slt = 2;
    localparam int op_sltu = 3;
    localparam int op_and = 4;
    localparam int op_nor = 5;
    localparam int op_or = 6;
    localparam int op_xor = 7;
    localparam int op_sll = 8;
    localparam int op_srl = 9;
    localparam int op_sra = 10;
    localparam int op_lu12i = 11;

    // one-hot bit positions of load_op, bits 7:5 spare
    localparam int ld_b = 0;
    localparam int ld_h = 1;
    localparam int ld_w = 2;
    localparam int ld_bu = 3;
    localparam int ld_hu = 4;

    // 3R opcodes, inst[31:15]
    localparam logic [16:0] opc_add_w = 17'h00020;
    localparam logic [16:0] opc_sub_w = 17'h00022;
    localparam logic [16:0] opc_slt = 17'h00024;
    localparam logic [16:0] opc_sltu = 17'h00025;
    localparam logic [16:0] opc_nor = 17'h00028;
    localparam logic [16:0] opc_and = 17'h00029;
    localparam logic [16:0] opc_or = 17'h0002a;
    localparam logic [16:0] opc_xor = 17'h0002b;
    localparam logic [16:0] opc_sll_w = 17'h0002e;
    localparam logic [16:0] opc_srl_w = 17'h0002f;
    localparam logic [16:0] opc_sra_w = 17'h00030;

    // 2RI12 opcodes, inst[31:22]
    localparam logic [9:0] opc_slti = 10'h008;
    localparam logic [9:0] opc_sltui = 10'h009;
    localparam logic [9:0] opc_addi_w = 10'h00a;
    localparam logic [9:0] opc_andi = 10'h00d;
    localparam logic [9:0] opc_ori = 10'h00e;
    localparam logic [9:0] opc_xori = 10'h00f;
    localparam logic [9:0] opc_ld_b = 10'h0a0;
    localparam logic [9:0] opc_ld_h = 10'h0a1;
    localparam logic [9:0] opc_ld_w = 10'h0a2;
    localparam logic [9:0] opc_st_w = 10'h0a6;
    localparam logic [9:0] opc_ld_bu = 10'h0a8;
    localparam logic [9:0] opc_ld_hu = 10'h0a9;

    typedef struct packed {
        logic [16:0] opcode;
        logic [4:0] rk;
        logic [4:0] rj;
        logic [4:0] rd;
    } r3_fmt;

    typedef struct packed {
        logic [9:0] opcode;
        logic [11:0] imm12;
        logic [4:0] rj;
        logic [4:0] rd;
    } ri12_fmt;

    typedef union packed {
        r3_fmt r3;
        ri12_fmt ri12;
    } inst_word_u;

endpackage

`default_nettype wire

// File: source/mem_stage.sv
`default_nettype none

module mem_stage (
    input logic clk,
    input logic rst,
    mem_bus_if.consumer up,
    input logic wb_ready,
    output logic wb_valid,
    output logic wb_we,
    output logic [31:0] wb_pc,
    output logic [31:0] wb_data,
    output logic [4:0] wb_dest
);

    logic [lite_pkg::xlen-1:0] dmem [lite_pkg::dmem_words];
    logic [$clog2(lite_pkg::dmem_words)-1:0] word_addr;
    logic [31:0] rdata;
    logic [31:0] shifted;
    logic [31:0] load_data;
    logic [31:0] result;
    logic accept;

    initial begin
        for (int i = 0; i < lite_pkg::dmem_words; i++) begin
            dmem[i] = '0;
        end
    end

    assign up.ready = ~rst & (~wb_valid | wb_ready);
    assign accept = up.valid & up.ready;

    assign word_addr = up.alu_result[$clog2(lite_pkg::dmem_words)+1:2];
    assign rdata = dmem[word_addr]; // async read at acceptance
    assign shifted = rdata >> {up.alu_result[1:0], 3'b000};

    assign load_data =
          ({32{up.load_op[lite_pkg::ld_b]}} & {{24{shifted[7]}}, shifted[7:0]})
        | ({32{up.load_op[lite_pkg::ld_bu]}} & {24'b0, shifted[7:0]})
        | ({32{up.load_op[lite_pkg::ld_h]}} & {{16{shifted[15]}}, shifted[15:0]})
        | ({32{up.load_op[lite_pkg::ld_hu]}} & {16'b0, shifted[15:0]})
        | ({32{up.load_op[lite_pkg::ld_w]}} & rdata);

    assign result = up.res_from_mem ? load_data : up.alu_result;

    always_ff @(posedge clk) begin
        if (accept && up.mem_we) begin
            dmem[word_addr] <= up.rkd_value; // st.w only, full word
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_valid <= 1'b0;
            wb_pc <= lite_pkg::reset_pc;
        end else begin
            if (up.ready) begin
                wb_valid <= up.valid;
            end
            if (accept) begin
                wb_pc <= up.pc;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            wb_we <= up.gr_we;
            wb_dest <= up.dest;
            wb_data <= result;
        end
    end

endmodule

`default_nettype wire

// File: verif/lite_pipe_checker.sv
`default_nettype none

module lite_pipe_checker (
    input logic clk,
    input logic rst,
    input logic inst_valid,
    input logic inst_ready,
    input logic [31:0] pc,
    input logic wb_ready,
    input logic wb_valid,
    input logic [31:0] wb_pc,
    input logic [4:0] wb_dest,
    input logic wb_we,
    input logic [31:0] wb_data
);
    timeunit 1ns;
    timeprecision 100ps;

    int unsigned fail_count = 0;
    logic wb_seen;

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_seen <= 1'b0;
        end else if (wb_valid) begin
            wb_seen <= 1'b1;
        end
    end

    ready_low_in_reset: assert property (@(posedge clk) rst |-> !inst_ready)
        else begin
            $error("inst_ready was high while rst was asserted");
            fail_count++;
        end

    valid_low_after_reset: assert property (@(posedge clk) rst |=> !wb_valid)
        else begin
            $error("wb_valid was high in the cycle after a reset cycle");
            fail_count++;
        end

    // wb_pc keeps its reset value until the first record shows up
    pc_holds_reset_value: assert property (@(posedge clk) disable iff (rst)
        !wb_seen && !wb_valid |-> wb_pc == lite_pkg::reset_pc)
        else begin
            $error("wb_pc left its reset value before the first writeback");
            fail_count++;
        end

    stall_holds_record: assert property (@(posedge clk) disable iff (rst)
        wb_valid && !wb_ready |=> wb_valid && $stable(wb_pc) && $stable(wb_dest)
            && $stable(wb_we) && $stable(wb_data))
        else begin
            $error("writeback record changed while wb_ready was low");
            fail_count++;
        end

    latency_three_cycles: assert property (@(posedge clk) disable iff (rst)
        inst_valid && inst_ready ##1 wb_ready [*2] |=> wb_valid && wb_pc == $past(pc, 3))
        else begin
            $error("accepted instruction did not reach writeback three cycles later");
            fail_count++;
        end

endmodule

bind lite_pipe_top lite_pipe_checker i_lite_pipe_checker (.*);

`default_nettype wire

// File: verif/tb_clock.sv
`default_nettype none

module tb_clock #(
    parameter real period = 8.0
) (
    output logic clk
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #(period / 2.0) clk = ~clk;
    end

endmodule

`default_nettype wire

// File: verif/tb_lite_pipe.sv
`default_nettype none

module tb_lite_pipe;
    timeunit 1ns;
    timeprecision 100ps;

    localparam logic [31:0] seed = 32'h99ce8f52;

    typedef struct {
        string name;
        logic [31:0] word;
        logic [31:0] a;
        logic [31:0] b;
    } stim_item;

    typedef struct {
        string name;
        logic [31:0] pc;
        logic [4:0] dest;
        logic we;
        logic [31:0] data;
    } wb_rec;

    logic clk;
    logic rst;
    logic inst_valid;
    logic inst_ready;
    logic [31:0] inst;
    logic [31:0] pc;
    logic [31:0] rj_value;
    logic [31:0] rkd_value;
    logic wb_ready;
    logic wb_valid;
    logic [31:0] wb_pc;
    logic [4:0] wb_dest;
    logic wb_we;
    logic [31:0] wb_data;

    string cur_name;
    logic stall_en;
    logic [31:0] rng;
    logic [31:0] stall_rng;
    logic [31:0] next_pc;
    logic [31:0] model_mem [lite_pkg::dmem_words];
    stim_item stim_q [$];
    wb_rec exp_q [$];
    int n_total = 0;
    int n_steady;
    int wb_count = 0;
    int mismatches = 0;
    int other_errors = 0;
    int protocol_errors;

    localparam logic [16:0] r3_opcs [11] = '{lite_pkg::opc_add_w, lite_pkg::opc_sub_w,
        lite_pkg::opc_slt, lite_pkg::opc_sltu, lite_pkg::opc_and, lite_pkg::opc_or,
        lite_pkg::opc_nor, lite_pkg::opc_xor, lite_pkg::opc_sll_w, lite_pkg::opc_srl_w,
        lite_pkg::opc_sra_w};
    string r3_names [11] = '{"add.w", "sub.w", "slt", "sltu", "and", "or", "nor", "xor",
        "sll.w", "srl.w", "sra.w"};
    localparam logic [9:0] imm_opcs [6] = '{lite_pkg::opc_addi_w, lite_pkg::opc_slti,
        lite_pkg::opc_sltui, lite_pkg::opc_andi, lite_pkg::opc_ori, lite_pkg::opc_xori};
    string imm_names [6] = '{"addi.w", "slti", "sltui", "andi", "ori", "xori"};

    tb_clock #(.period(8.0)) i_tb_clock (.clk(clk));

    lite_pipe_top i_lite_pipe_top (.*);

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] rand_word();
        rng = xorshift(rng);
        return rng;
    endfunction

    function automatic logic [31:0] sext12(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    function automatic logic [31:0] enc_r3(input logic [16:0] opc);
        lite_pkg::inst_word_u w;
        w = rand_word(); // random rk, rj, rd
        w.r3.opcode = opc;
        return w;
    endfunction

    function automatic logic [31:0] enc_ri(input logic [9:0] opc, input logic [11:0] imm);
        lite_pkg::inst_word_u w;
        w = rand_word();
        w.ri12.opcode = opc;
        w.ri12.imm12 = imm;
        return w;
    endfunction

    task automatic push(input string mnem, input logic [31:0] word, input logic [31:0] a,
                        input logic [31:0] b);
        stim_item s;
        s.name = $sformatf("%s #%0d", mnem, stim_q.size());
        s.word = word;
        s.a = a;
        s.b = b;
        stim_q.push_back(s);
    endtask

    task automatic build_stimulus();
        logic [31:0] a;
        logic [31:0] base;
        logic [31:0] data;
        logic [11:0] imm;
        for (int i = 0; i < 11; i++) begin
            for (int k = 0; k < 4; k++) begin
                a = (k == 0) ? 32'h80000000 : rand_word(); // signed and unsigned compares differ
                push(r3_names[i], enc_r3(r3_opcs[i]), a, (k == 0) ? 32'h1 : rand_word());
            end
        end
        n_steady = stim_q.size();
        for (int i = 0; i < 6; i++) begin
            for (int k = 0; k < 4; k++) begin
                imm = (k == 0) ? 12'hfff : 12'(rand_word());
                a = (k == 0) ? 32'h1 : rand_word();
                push(imm_names[i], enc_ri(imm_opcs[i], imm), a, rand_word());
            end
        end
        for (int g = 0; g < 4; g++) begin
            base = {24'b0, 6'(rand_word()), 2'b00};
            imm = 12'(rand_word());
            data = (g == 0) ? 32'h80ff7f01 : rand_word();
            push("st.w", enc_ri(lite_pkg::opc_st_w, imm), base - sext12(imm), data);
            push("ld.w", enc_ri(lite_pkg::opc_ld_w, imm), base - sext12(imm), rand_word());
            for (int off = 0; off < 4; off++) begin
                a = base + off - sext12(imm);
                push("ld.b", enc_ri(lite_pkg::opc_ld_b, imm), a, rand_word());
                push("ld.bu", enc_ri(lite_pkg::opc_ld_bu, imm), a, rand_word());
                if (off % 2 == 0) begin
                    push("ld.h", enc_ri(lite_pkg::opc_ld_h, imm), a, rand_word());
                    push("ld.hu", enc_ri(lite_pkg::opc_ld_hu, imm), a, rand_word());
                end
            end
        end
        for (int k = 0; k < 3; k++) begin
            push("unknown", {10'h3ff, 22'(rand_word())}, rand_word(), rand_word());
        end
    endtask

    // expected writeback from the ISA rules, stores update the model memory
    task automatic model_step(input string name, input logic [31:0] word,
                              input logic [31:0] a, input logic [31:0] b,
                              input logic [31:0] p);
        lite_pkg::inst_word_u iw;
        logic [31:0] sext;
        logic [31:0] zext;
        logic [31:0] addr;
        logic [31:0] mword;
        logic [31:0] lane;
        int idx;
        wb_rec rec;
        iw = word;
        sext = sext12(iw.ri12.imm12);
        zext = {20'b0, iw.ri12.imm12};
        addr = a + sext;
        idx = (addr >> 2) % lite_pkg::dmem_words;
        mword = model_mem[idx];
        lane = mword >> (8 * addr[1:0]);
        rec.name = name;
        rec.pc = p;
        rec.dest = iw.r3.rd;
        rec.we = 1'b1;
        rec.data = '0;
        case (iw.r3.opcode)
            lite_pkg::opc_add_w: rec.data = a + b;
            lite_pkg::opc_sub_w: rec.data = a - b;
            lite_pkg::opc_slt: rec.data = {31'b0, $signed(a) < $signed(b)};
            lite_pkg::opc_sltu: rec.data = {31'b0, a < b};
            lite_pkg::opc_and: rec.data = a & b;
            lite_pkg::opc_or: rec.data = a | b;
            lite_pkg::opc_nor: rec.data = ~(a | b);
            lite_pkg::opc_xor: rec.data = a ^ b;
            lite_pkg::opc_sll_w: rec.data = a << b[4:0];
            lite_pkg::opc_srl_w: rec.data = a >> b[4:0];
            lite_pkg::opc_sra_w: rec.data = $signed(a) >>> b[4:0];
            default: begin
                case (iw.ri12.opcode)
                    lite_pkg::opc_addi_w: rec.data = a + sext;
                    lite_pkg::opc_slti: rec.data = {31'b0, $signed(a) < $signed(sext)};
                    lite_pkg::opc_sltui: rec.data = {31'b0, a < sext};
                    lite_pkg::opc_andi: rec.data = a & zext;
                    lite_pkg::opc_ori: rec.data = a | zext;
                    lite_pkg::opc_xori: rec.data = a ^ zext;
                    lite_pkg::opc_ld_b: rec.data = {{24{lane[7]}}, lane[7:0]};
                    lite_pkg::opc_ld_bu: rec.data = {24'b0, lane[7:0]};
                    lite_pkg::opc_ld_h: rec.data = {{16{lane[15]}}, lane[15:0]};
                    lite_pkg::opc_ld_hu: rec.data = {16'b0, lane[15:0]};
                    lite_pkg::opc_ld_w: rec.data = mword;
                    lite_pkg::opc_st_w: begin
                        model_mem[idx] = b;
                        rec.we = 1'b0;
                    end
                    default: rec.we = 1'b0; // bubble
                endcase
            end
        endcase
        exp_q.push_back(rec);
    endtask

    task automatic compare(input string test, input string field,
                           input logic [31:0] expected, input logic [31:0] actual);
        value_match: assert (actual === expected) else begin
            $display("ERROR %s %s: expected %h, actual %h", test, field, expected, actual);
            mismatches++;
        end
    endtask

    task automatic check_writeback();
        wb_rec exp;
        wb_count++;
        outstanding: assert (exp_q.size() != 0) else begin
            $display("writeback at pc %h arrived with no instruction outstanding", wb_pc);
            other_errors++;
        end
        if (exp_q.size() != 0) begin
            exp = exp_q.pop_front();
            compare(exp.name, "pc", exp.pc, wb_pc);
            compare(exp.name, "we", {31'b0, exp.we}, {31'b0, wb_we});
            if (exp.we) begin
                compare(exp.name, "dest", {27'b0, exp.dest}, {27'b0, wb_dest});
                compare(exp.name, "data", exp.data, wb_data);
            end
        end
    endtask

    task automatic issue(input stim_item s);
        inst_valid <= 1'b1;
        inst <= s.word;
        rj_value <= s.a;
        rkd_value <= s.b;
        pc <= next_pc;
        cur_name <= s.name;
        @(posedge clk);
        while (!inst_ready) @(posedge clk);
        next_pc = next_pc + 32'd4;
    endtask

    always @(posedge clk) begin
        if (rst || !stall_en) begin
            wb_ready <= 1'b1;
        end else begin
            stall_rng = xorshift(stall_rng);
            wb_ready <= (stall_rng[2:0] > 3'd2); // roughly five of eight cycles ready
        end
    end

    always @(posedge clk) begin
        if (!rst && wb_valid && wb_ready) begin
            check_writeback();
        end
        if (!rst && inst_valid && inst_ready) begin
            model_step(cur_name, inst, rj_value, rkd_value, pc);
        end
    end

    initial begin
        wait (n_total != 0);
        repeat (n_total * 40 + 200) @(posedge clk);
        $display("timeout: the pipeline stopped before all writebacks came out");
        $display("*** FAILED ***");
        $finish;
    end

    initial begin
        rst = 1'b1;
        inst_valid = 1'b0;
        inst = '0;
        pc = '0;
        rj_value = '0;
        rkd_value = '0;
        wb_ready = 1'b1;
        stall_en = 1'b0;
        cur_name = "";
        rng = seed;
        stall_rng = xorshift(~seed);
        next_pc = lite_pkg::reset_pc;
        for (int i = 0; i < lite_pkg::dmem_words; i++) begin
            model_mem[i] = '0;
        end
        build_stimulus();
        n_total = stim_q.size();
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        for (int i = 0; i < n_total; i++) begin
            if (i == n_steady) begin
                stall_en <= 1'b1; // 3R group ran with wb_ready held high
            end
            if (i >= n_steady && rand_word() % 8 == 0) begin
                inst_valid <= 1'b0;
                @(posedge clk);
            end
            issue(stim_q[i]);
        end
        inst_valid <= 1'b0;
        @(posedge clk);
        while (exp_q.size() != 0) @(posedge clk);
        repeat (4) @(posedge clk);
        record_count: assert (wb_count == n_total) else begin
            $display("%0d writebacks came out for %0d instructions", wb_count, n_total);
            other_errors++;
        end
        protocol_errors = i_lite_pipe_top.i_lite_pipe_checker.fail_count;
        $display("errors: %0d mismatches, %0d protocol, %0d other",
                 mismatches, protocol_errors, other_errors);
        if (mismatches + protocol_errors + other_errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire
